//--- compile.f
+incdir+rtl
+incdir+dv
rtl/dino_pkg.sv
rtl/tick_divider.sv
rtl/obstacle_spawner.sv
rtl/scroll_field.sv
rtl/matrix_scan.sv
rtl/dino_obstacle_top.sv
dv/dino_obstacle_tb.sv

//--- Bender.yml
package:
  name: dino_obstacle

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dino_pkg.sv
      - rtl/tick_divider.sv
      - rtl/obstacle_spawner.sv
      - rtl/scroll_field.sv
      - rtl/matrix_scan.sv
      - rtl/dino_obstacle_top.sv

  - target: test
    include_dirs:
      - rtl
      - dv
    files:
      - dv/dino_obstacle_tb.sv

//--- dv/dino_tb_checks.svh
task automatic report_failure(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at the first failure");
endtask

task automatic check_row(input string name, input dino_pkg::row_mask_t got,
                         input dino_pkg::row_mask_t exp);
    if (got !== exp) begin
        report_failure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                 $time, name, got, exp));
    end
endtask

task automatic check_col(input string name, input dino_pkg::panel_col_t got,
                         input dino_pkg::panel_col_t exp);
    if (got !== exp) begin
        report_failure($sformatf("Error at %0t ns: %s is %h, expected %h",
                                 $time, name, got, exp));
    end
endtask

task automatic check_pattern(input string name, input dino_pkg::pattern_e got,
                             input dino_pkg::pattern_e exp);
    if (got !== exp) begin
        report_failure($sformatf("Error at %0t ns: %s is %0d, expected %0d",
                                 $time, name, got, exp));
    end
endtask

// galois form with taps 32,22,2,1
function automatic logic [31:0] galois_step(input logic [31:0] s);
    if (s[0]) begin
        return (s >> 1) ^ 32'h8020_0003;
    end
    return s >> 1;
endfunction

task automatic rand_word(output logic [31:0] w);
    int b;
    w = '0;
    for (b = 0; b < 32; b++) begin
        w          = {w[30:0], rand_state[0]};   // one step per bit
        rand_state = galois_step(rand_state);
    end
endtask

task automatic wait_scroll_tick();
    int n;
    n = 0;
    do begin
        clock_cycle();
        n++;
    end while (!m_scroll_fired && n <= SCROLL_DIV);
    if (!m_scroll_fired) begin
        report_failure($sformatf("no scroll tick arrived within %0d clocks", n));
    end
endtask

task automatic wait_first_strobe();
    int n;
    n = 0;
    while (o_dot_row === '1 && n <= 4 * SCAN_DIV) begin
        clock_cycle();
        n++;
    end
    if (o_dot_row === '1) begin
        report_failure("row select stayed idle long after reset was released");
    end else if (n != SCAN_DIV + 1) begin
        report_failure($sformatf("first scan strobe came after %0d clocks instead of %0d",
                                 n, SCAN_DIV + 1));
    end
endtask

//--- dv/dino_obstacle_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dino_defines.svh"

module dino_obstacle_tb;

    localparam int SCROLL_DIV = 64;
    localparam int SCAN_DIV   = 4;
    localparam int N_ENTRIES  = 8;
    localparam int SKIP_TICKS = 24;                  // old field content gone by then

    logic                       clk;
    logic                       reset;
    logic                       i_seed_load;
    logic [`DINO_LFSR_BITS-1:0] i_seed;
    dino_pkg::row_mask_t        o_dot_row;
    dino_pkg::panel_col_t       o_dot_col1;
    dino_pkg::panel_col_t       o_dot_col2;

    // reference model
    int                         m_scroll_cnt;
    int                         m_scan_cnt;
    logic                       m_scroll_tick;
    logic                       m_scan_tick;
    logic                       m_scroll_fired;  // tick consumed at the last edge
    logic [`DINO_LFSR_BITS-1:0] m_lfsr;
    dino_pkg::pattern_e         m_code;
    dino_pkg::row_mask_t        m_mask;
    int                         m_gap;
    logic [1:0]                 m_stage [`DINO_ROWS];
    dino_pkg::field_row_t       m_field [`DINO_ROWS];
    dino_pkg::row_idx_t         m_row;
    dino_pkg::row_mask_t        m_dot_row;
    dino_pkg::panel_col_t       m_col1;
    dino_pkg::panel_col_t       m_col2;
    logic [7:0]                 seen_codes;

    int                         cycle_cnt;
    int                         last_change;
    dino_pkg::row_mask_t        last_row_obs;

    // stimulus table of seed, scroll ticks, reload flag and locked flag
    logic [31:0]                tbl_seed [N_ENTRIES];
    int                         tbl_ticks [N_ENTRIES];
    bit                         tbl_reload [N_ENTRIES];
    bit                         tbl_locked [N_ENTRIES];

    logic [31:0]                rand_state;
    bit                         recording;
    logic [23:0]                frame_q [$];
    logic [23:0]                prev_frame_q [$];

    `include "dino_tb_checks.svh"

    dino_obstacle_top #(
        .SCROLL_DIV (SCROLL_DIV),
        .SCAN_DIV   (SCAN_DIV)
    ) dino_obstacle_top_i (
        .clk         (clk),
        .reset       (reset),
        .i_seed_load (i_seed_load),
        .i_seed      (i_seed),
        .o_dot_row   (o_dot_row),
        .o_dot_col1  (o_dot_col1),
        .o_dot_col2  (o_dot_col2)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic dino_pkg::row_mask_t pattern_rows(input dino_pkg::pattern_e code);
        dino_pkg::row_mask_t m;
        m = '0;
        case (code)
            dino_pkg::pat_ground_low, dino_pkg::pat_ground_low_b: begin
                m[5] = 1'b1;
                m[6] = 1'b1;
                m[7] = 1'b1;
            end
            dino_pkg::pat_sky_wall: m[3:0] = 4'hf;
            dino_pkg::pat_split: begin
                m[0] = 1'b1;
                m[1] = 1'b1;
                m[6] = 1'b1;
                m[7] = 1'b1;
            end
            dino_pkg::pat_edge_pair: begin
                m[0] = 1'b1;
                m[7] = 1'b1;
            end
            default: m = '0;                         // clear codes
        endcase
        return m;
    endfunction

    task automatic model_reset();
        int r;
        m_scroll_cnt   = 0;
        m_scan_cnt     = 0;
        m_scroll_tick  = 1'b0;
        m_scan_tick    = 1'b0;
        m_scroll_fired = 1'b0;
        m_lfsr         = `DINO_LFSR_RESET;
        m_code         = dino_pkg::pat_ground_low;
        m_mask         = '0;
        m_gap          = 0;
        m_row          = '0;
        m_dot_row      = '1;
        m_col1         = '0;
        m_col2         = '0;
        for (r = 0; r < `DINO_ROWS; r++) begin
            m_stage[r] = '0;
            m_field[r] = '0;
        end
    endtask

    // one clock edge with every stage reading the old state
    task automatic model_step();
        dino_pkg::row_mask_t   sel;
        logic [`DINO_COLS+1:0] chain;
        logic                  fb;
        int                    r;
        if (!reset) begin
            model_reset();
        end else begin
            if (m_scan_tick) begin
                sel = '1;
                sel[`DINO_ROWS - 1 - int'(m_row)] = 1'b0;
                m_dot_row = sel;
                m_col1    = m_field[m_row][`DINO_COLS-1:`DINO_PANEL_COLS];
                m_col2    = m_field[m_row][`DINO_PANEL_COLS-1:0];
                m_row     = m_row + 1'b1;
            end
            if (m_scroll_tick) begin
                if (m_gap == `DINO_GAP_TICKS - 1) begin
                    m_gap = 0;
                    for (r = 0; r < `DINO_ROWS; r++) begin
                        m_stage[r] = {2{m_mask[r]}};
                    end
                end else begin
                    m_gap++;
                    for (r = 0; r < `DINO_ROWS; r++) begin
                        chain      = {m_field[r], m_stage[r]} << 1;
                        m_field[r] = chain[`DINO_COLS+1:2];
                        m_stage[r] = chain[1:0];
                    end
                end
            end
            if (i_seed_load) begin
                m_lfsr = i_seed;
            end else if (m_scroll_tick) begin
                m_code = dino_pkg::pattern_e'(m_lfsr[2:0]);
                m_mask = pattern_rows(m_code);
                seen_codes[m_code] = 1'b1;
                fb     = ~(m_lfsr[31] ^ m_lfsr[21] ^ m_lfsr[1] ^ m_lfsr[0]);
                m_lfsr = {m_lfsr[30:0], fb};
            end
            m_scroll_fired = m_scroll_tick;
            m_scroll_tick  = (m_scroll_cnt == SCROLL_DIV - 1);
            m_scroll_cnt   = m_scroll_tick ? 0 : m_scroll_cnt + 1;
            m_scan_tick    = (m_scan_cnt == SCAN_DIV - 1);
            m_scan_cnt     = m_scan_tick ? 0 : m_scan_cnt + 1;
        end
    endtask

    task automatic compare_outputs();
        check_row("o_dot_row", o_dot_row, m_dot_row);
        check_col("o_dot_col1", o_dot_col1, m_col1);
        check_col("o_dot_col2", o_dot_col2, m_col2);
        if (o_dot_row !== last_row_obs) begin
            if (last_change >= 0 && cycle_cnt - last_change != SCAN_DIV) begin
                report_failure($sformatf("row select moved after %0d clocks instead of %0d",
                                         cycle_cnt - last_change, SCAN_DIV));
            end
            if ($countones(~o_dot_row) != 1) begin
                report_failure("row select does not have exactly one low bit");
            end
            if (recording) begin
                frame_q.push_back({o_dot_row, o_dot_col1, o_dot_col2});
            end
            last_change  = cycle_cnt;
            last_row_obs = o_dot_row;
        end
    endtask

    task automatic clock_cycle();
        @(posedge clk);
        model_step();
        #1;                                          // outputs settled and inputs change here
        cycle_cnt++;
        compare_outputs();
    endtask

    task automatic load_seed(input logic [`DINO_LFSR_BITS-1:0] seed);
        i_seed      = seed;
        i_seed_load = 1'b1;
        clock_cycle();
        i_seed_load = 1'b0;
    endtask

    task automatic build_table();
        int e;
        for (e = 0; e < N_ENTRIES; e++) begin
            tbl_ticks[e]  = 40;                      // multiple of the gap period
            tbl_reload[e] = 1'b0;
            tbl_locked[e] = 1'b0;
        end
        rand_word(tbl_seed[0]);
        tbl_seed[1]   = tbl_seed[0];
        tbl_reload[1] = 1'b1;
        rand_word(tbl_seed[2]);
        tbl_seed[3]   = 32'h0000_0000;
        tbl_seed[4]   = 32'h0000_0000;
        tbl_reload[4] = 1'b1;
        tbl_seed[5]   = 32'hffff_ffff;               // xnor lock-up state
        tbl_locked[5] = 1'b1;
        rand_word(tbl_seed[6]);
        rand_word(tbl_seed[7]);
    endtask

    task automatic run_entry(input int e);
        int k;
        int i;
        prev_frame_q = frame_q;
        frame_q.delete();
        load_seed(tbl_seed[e]);
        for (k = 0; k < tbl_ticks[e]; k++) begin
            recording = (k >= SKIP_TICKS);
            wait_scroll_tick();
            if (tbl_locked[e]) begin
                check_pattern("pattern code", m_code, dino_pkg::pat_clear_c);
            end
        end
        recording = 1'b0;
        if (tbl_locked[e]) begin
            check_col("o_dot_col1", o_dot_col1, '0);  // everything scrolled out
            check_col("o_dot_col2", o_dot_col2, '0);
        end
        if (tbl_reload[e]) begin
            if (frame_q.size() == 0 || frame_q.size() != prev_frame_q.size()) begin
                report_failure($sformatf("reloaded seed gave %0d frames, first run gave %0d",
                                         frame_q.size(), prev_frame_q.size()));
            end
            for (i = 0; i < frame_q.size(); i++) begin
                if (frame_q[i] !== prev_frame_q[i]) begin
                    report_failure($sformatf("Error at %0t ns: frame %0d is %h, expected %h",
                                             $time, i, frame_q[i], prev_frame_q[i]));
                end
            end
        end
    endtask

    initial begin
        int e;
        int k;
        reset        = 1'b0;
        i_seed_load  = 1'b0;
        i_seed       = '0;
        rand_state   = 32'hb3e8_2d50;
        cycle_cnt    = 0;
        last_change  = -1;
        last_row_obs = '1;
        recording    = 1'b0;
        seen_codes   = '0;
        model_reset();
        build_table();
        repeat (10) clock_cycle();
        reset = 1'b1;
        wait_first_strobe();
        for (k = 0; k < 8; k++) begin
            wait_scroll_tick();                      // lfsr from its reset value
        end
        for (e = 0; e < N_ENTRIES; e++) begin
            run_entry(e);
        end
        if (seen_codes == 8'hff) begin
            $display("ALL CHECKS PASSED");
            $finish;
        end else begin
            report_failure($sformatf("only pattern codes %b were produced", seen_codes));
        end
    end

endmodule

`default_nettype wire

//--- rtl/dino_obstacle_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dino_defines.svh"

module dino_obstacle_top #(
    parameter int SCROLL_DIV = `DINO_SCROLL_DIV,
    parameter int SCAN_DIV   = `DINO_SCAN_DIV
) (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_seed_load,
    input  logic [`DINO_LFSR_BITS-1:0]  i_seed,
    output dino_pkg::row_mask_t         o_dot_row,
    output dino_pkg::panel_col_t        o_dot_col1,
    output dino_pkg::panel_col_t        o_dot_col2
);

    logic                 scroll_tick;
    logic                 scan_tick;
    dino_pkg::row_mask_t  spawn_mask;
    dino_pkg::field_row_t field_rows [`DINO_ROWS];

    tick_divider #(.DIVISOR(SCROLL_DIV)) scroll_div (
        .clk    (clk),
        .reset  (reset),
        .o_tick (scroll_tick)
    );

    tick_divider #(.DIVISOR(SCAN_DIV)) scan_div (
        .clk    (clk),
        .reset  (reset),
        .o_tick (scan_tick)
    );

    obstacle_spawner obstacle_spawner_i (
        .clk         (clk),
        .reset       (reset),
        .i_tick      (scroll_tick),
        .i_seed_load (i_seed_load),
        .i_seed      (i_seed),
        .o_mask      (spawn_mask)
    );

    scroll_field scroll_field_i (
        .clk     (clk),
        .reset   (reset),
        .i_tick  (scroll_tick),
        .i_mask  (spawn_mask),
        .o_field (field_rows)
    );

    matrix_scan matrix_scan_i (
        .clk        (clk),
        .reset      (reset),
        .i_tick     (scan_tick),
        .i_field    (field_rows),
        .o_dot_row  (o_dot_row),
        .o_dot_col1 (o_dot_col1),
        .o_dot_col2 (o_dot_col2)
    );

endmodule

`default_nettype wire

//--- rtl/matrix_scan.sv
`timescale 1ns/1ns
`default_nettype none

`include "dino_defines.svh"

module matrix_scan (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_tick,
    input  dino_pkg::field_row_t i_field [`DINO_ROWS],
    output dino_pkg::row_mask_t  o_dot_row,
    output dino_pkg::panel_col_t o_dot_col1,
    output dino_pkg::panel_col_t o_dot_col2
);

    dino_pkg::row_idx_t   row_cnt;
    dino_pkg::row_mask_t  row_sel;
    dino_pkg::field_row_t cur_row;

    assign cur_row = i_field[row_cnt];

    // active low, row 0 drives the top bit
    always_comb begin
        row_sel = '1;
        row_sel[`DINO_ROWS - 1 - int'(row_cnt)] = 1'b0;
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            row_cnt    <= '0;
            o_dot_row  <= '1;                        // all rows off
            o_dot_col1 <= '0;
            o_dot_col2 <= '0;
        end else if (i_tick) begin
            o_dot_row  <= row_sel;
            o_dot_col1 <= cur_row[`DINO_COLS-1:`DINO_PANEL_COLS];   // left panel
            o_dot_col2 <= cur_row[`DINO_PANEL_COLS-1:0];
            row_cnt    <= row_cnt + 1'b1;            // wraps after 7
        end
    end

endmodule

`default_nettype wire

//--- rtl/scroll_field.sv
`timescale 1ns/1ns
`default_nettype none

`include "dino_defines.svh"

module scroll_field (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 i_tick,
    input  dino_pkg::row_mask_t  i_mask,
    output dino_pkg::field_row_t o_field [`DINO_ROWS]
);

    localparam int GAP_W = $clog2(`DINO_GAP_TICKS);
    localparam logic [GAP_W-1:0] GAP_LAST = GAP_W'(`DINO_GAP_TICKS - 1);

    logic [GAP_W-1:0]     gap_cnt;
    logic                 load_tick;
    logic                 shift_tick;
    logic [1:0]           stage [`DINO_ROWS];     // obstacle waiting off the right edge
    dino_pkg::field_row_t field_map [`DINO_ROWS];

    assign load_tick  = i_tick && (gap_cnt == GAP_LAST);
    assign shift_tick = i_tick && (gap_cnt != GAP_LAST);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            gap_cnt <= '0;
        end else if (load_tick) begin
            gap_cnt <= '0;
        end else if (shift_tick) begin
            gap_cnt <= gap_cnt + 1'b1;
        end
    end

    // each row is one 18-bit chain, field on top of the staging pair
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            for (int r = 0; r < `DINO_ROWS; r++) begin
                stage[r]     <= '0;
                field_map[r] <= '0;
            end
        end else if (load_tick) begin
            for (int r = 0; r < `DINO_ROWS; r++) begin
                stage[r] <= {2{i_mask[r]}};            // two columns wide
            end
        end else if (shift_tick) begin
            for (int r = 0; r < `DINO_ROWS; r++) begin
                field_map[r] <= {field_map[r][`DINO_COLS-2:0], stage[r][1]};
                stage[r]     <= {stage[r][0], 1'b0};
            end
        end
    end

    assign o_field = field_map;

endmodule

`default_nettype wire

//--- rtl/obstacle_spawner.sv
`timescale 1ns/1ns
`default_nettype none

`include "dino_defines.svh"

module obstacle_spawner (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_tick,
    input  logic                        i_seed_load,
    input  logic [`DINO_LFSR_BITS-1:0]  i_seed,
    output dino_pkg::row_mask_t         o_mask
);

    // row masks, row 0 at the top of the matrix
    localparam dino_pkg::row_mask_t MASK_GROUND = 8'b1110_0000;
    localparam dino_pkg::row_mask_t MASK_SKY    = 8'b0000_1111;
    localparam dino_pkg::row_mask_t MASK_SPLIT  = 8'b1100_0011;
    localparam dino_pkg::row_mask_t MASK_EDGES  = 8'b1000_0001;
    localparam dino_pkg::row_mask_t MASK_CLEAR  = 8'b0000_0000;

    logic [`DINO_LFSR_BITS-1:0] lfsr;
    logic                       feedback;
    dino_pkg::pattern_e         pat_code;
    dino_pkg::row_mask_t        pat_mask;

    // xnor taps 32,22,2,1; all ones is the lock-up state
    assign feedback = ~(lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]);

    assign pat_code = dino_pkg::pattern_e'(lfsr[2:0]);

    always_comb begin
        case (pat_code)
            dino_pkg::pat_ground_low:   pat_mask = MASK_GROUND;
            dino_pkg::pat_sky_wall:     pat_mask = MASK_SKY;
            dino_pkg::pat_split:        pat_mask = MASK_SPLIT;
            dino_pkg::pat_ground_low_b: pat_mask = MASK_GROUND;
            dino_pkg::pat_edge_pair:    pat_mask = MASK_EDGES;
            dino_pkg::pat_clear_a:      pat_mask = MASK_CLEAR;
            dino_pkg::pat_clear_b:      pat_mask = MASK_CLEAR;
            dino_pkg::pat_clear_c:      pat_mask = MASK_CLEAR;
            default:                    pat_mask = MASK_CLEAR;
        endcase
    end

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            lfsr   <= `DINO_LFSR_RESET;
            o_mask <= '0;
        end else if (i_seed_load) begin
            lfsr <= i_seed;                          // seed beats tick
        end else if (i_tick) begin
            lfsr   <= {lfsr[`DINO_LFSR_BITS-2:0], feedback};
            o_mask <= pat_mask;                      // from the old state
        end
    end

endmodule

`default_nettype wire

//--- rtl/tick_divider.sv
`timescale 1ns/1ns
`default_nettype none

module tick_divider #(
    parameter int DIVISOR = 2
) (
    input  logic clk,
    input  logic reset,
    output logic o_tick
);

    localparam int CNT_W = (DIVISOR > 1) ? $clog2(DIVISOR) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIVISOR - 1);

    logic [CNT_W-1:0] count;
    logic             wrap;

    assign wrap = (count == CNT_LAST);

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            count  <= '0;
            o_tick <= 1'b0;
        end else begin
            o_tick <= wrap;                  // one cycle wide
            if (wrap) begin
                count <= '0;
            end else begin
                count <= count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dino_pkg.sv
`default_nettype none

`include "dino_defines.svh"

package dino_pkg;

    typedef logic [`DINO_ROWS-1:0] row_mask_t;        // 1 = obstacle in that row
    typedef logic [`DINO_COLS-1:0] field_row_t;       // bit 15 is leftmost
    typedef logic [`DINO_PANEL_COLS-1:0] panel_col_t;
    typedef logic [2:0] row_idx_t;

    // codes taken from the low three lfsr bits
    typedef enum logic [2:0] {
        pat_ground_low   = 3'd0,
        pat_sky_wall     = 3'd1,
        pat_split        = 3'd2,
        pat_ground_low_b = 3'd3,
        pat_edge_pair    = 3'd4,
        pat_clear_a      = 3'd5,
        pat_clear_b      = 3'd6,
        pat_clear_c      = 3'd7
    } pattern_e;

endpackage

`default_nettype wire

//--- rtl/dino_defines.svh
`ifndef DINO_DEFINES_SVH
`define DINO_DEFINES_SVH

// matrix geometry, two panels side by side
`define DINO_ROWS        8
`define DINO_COLS        16
`define DINO_PANEL_COLS  8

// obstacle generator
`define DINO_LFSR_BITS   32
`define DINO_LFSR_RESET  32'h0000_0000

// one load tick then three shift ticks
`define DINO_GAP_TICKS   4

// clocks per strobe
`define DINO_SCROLL_DIV  25000000
`define DINO_SCAN_DIV    25000

`endif
